//--- hw/udp_echo_pkg.sv
/*
 * UDP echo core shared widths, echo port and payload FIFO sizing
 */
package udp_echo_pkg;

    // Payload byte lane
    localparam int DATA_W = 8;

    // UDP header field widths
    localparam int PORT_W = 16;
    localparam int LEN_W  = 16;

    // IPv4 address width
    localparam int IP_W = 32;

    // Datagrams to this port are echoed, all others dropped
    localparam logic [PORT_W-1:0] ECHO_PORT = 16'd1234;

    // Payload buffer sizing
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

endpackage

//--- hw/udp_echo_ctrl.sv
/*
 * UDP echo frame controller
 * Accepts headers, picks echo or drop by destination port, steers payload beats
 */
`timescale 1ns/1ps

module udp_echo_ctrl
    import udp_echo_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // Incoming header handshake
    input  logic              rx_hdr_valid,
    output logic              rx_hdr_ready,
    input  logic [PORT_W-1:0] rx_dest_port,

    // Incoming payload handshake
    input  logic              rx_payload_tvalid,
    input  logic              rx_payload_tlast,
    output logic              rx_payload_tready,

    // Reply header buffer
    input  logic              tx_hdr_valid,
    output logic              hdr_load,

    // Payload FIFO write side
    input  logic              fifo_full,
    output logic              fifo_wr
);

    // Two-state FSM: 0 idle, 1 payload phase
    logic payload_phase;
    // Selects echo (1) or drop (0) for the current datagram
    logic echo_mode;

    logic port_match;
    logic hdr_accept;
    logic beat_accept;
    logic last_accept;

    assign port_match = (rx_dest_port == ECHO_PORT);

    // Hold off the next header until the reply buffer is free
    assign rx_hdr_ready = !payload_phase && !tx_hdr_valid;
    assign hdr_accept   = rx_hdr_valid && rx_hdr_ready;
    assign hdr_load     = hdr_accept && port_match;

    // Drop mode swallows every beat; echo mode follows FIFO space
    assign rx_payload_tready = payload_phase && (!echo_mode || !fifo_full);

    assign beat_accept = rx_payload_tvalid && rx_payload_tready;
    assign last_accept = beat_accept && rx_payload_tlast;
    assign fifo_wr     = beat_accept && echo_mode;

    always_ff @(posedge clk) begin
        if (rst) begin
            payload_phase <= 1'b0;
            echo_mode     <= 1'b0;
        end else begin
            if (!payload_phase) begin
                if (hdr_accept) begin
                    payload_phase <= 1'b1;
                    echo_mode     <= port_match;
                end
            end else if (last_accept) begin
                payload_phase <= 1'b0;
                echo_mode     <= 1'b0;
            end
        end
    end

    // Offered header keeps valid and its port until it is taken
    a_hdr_hold: assert property (
        @(posedge clk) disable iff (rst)
        rx_hdr_valid && !rx_hdr_ready |=> rx_hdr_valid && $stable(rx_dest_port)
    );

    // Offered payload beat keeps valid and its last flag until it is taken
    a_beat_hold: assert property (
        @(posedge clk) disable iff (rst)
        rx_payload_tvalid && !rx_payload_tready
            |=> rx_payload_tvalid && $stable(rx_payload_tlast)
    );

endmodule

//--- hw/reply_hdr_reg.sv
/*
 * UDP reply header register
 * Holds one echo header with addresses and ports swapped until taken
 */
`timescale 1ns/1ps

module reply_hdr_reg
    import udp_echo_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // Load strobe from the frame controller
    input  logic              hdr_load,

    // Received header fields
    input  logic [IP_W-1:0]   rx_ip_source_ip,
    input  logic [PORT_W-1:0] rx_source_port,
    input  logic [PORT_W-1:0] rx_dest_port,
    input  logic [LEN_W-1:0]  rx_length,

    // Reply header to the downstream stack
    output logic              tx_hdr_valid,
    input  logic              tx_hdr_ready,
    output logic [IP_W-1:0]   tx_ip_dest_ip,
    output logic [PORT_W-1:0] tx_source_port,
    output logic [PORT_W-1:0] tx_dest_port,
    output logic [LEN_W-1:0]  tx_length
);

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
        end else if (hdr_load) begin
            tx_hdr_valid <= 1'b1;
        end else if (tx_hdr_ready) begin
            tx_hdr_valid <= 1'b0;
        end
    end

    // Reply goes back to the sender, from the port it targeted
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            tx_ip_dest_ip  <= rx_ip_source_ip;
            tx_source_port <= rx_dest_port;
            tx_dest_port   <= rx_source_port;
            tx_length      <= rx_length;
        end
    end

    // Pending header keeps valid and its fields until the downstream takes it
    a_hdr_stable: assert property (
        @(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready
            |=> tx_hdr_valid
                && $stable({tx_ip_dest_ip, tx_source_port, tx_dest_port, tx_length})
    );

endmodule

//--- hw/payload_fifo.sv
/*
 * Payload byte FIFO
 * Circular buffer of data, last and user with a registered stream output
 */
`timescale 1ns/1ps

module payload_fifo
    import udp_echo_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // Write side, qualified by the frame controller
    input  logic              fifo_wr,
    input  logic [DATA_W-1:0] rx_payload_tdata,
    input  logic              rx_payload_tlast,
    input  logic              rx_payload_tuser,
    output logic              fifo_full,

    // Outgoing payload stream
    output logic [DATA_W-1:0] tx_payload_tdata,
    output logic              tx_payload_tvalid,
    output logic              tx_payload_tlast,
    output logic              tx_payload_tuser,
    input  logic              tx_payload_tready
);

    // Entry layout is {user, last, data}
    logic [DATA_W+1:0] mem [FIFO_DEPTH];

    // Extra MSB tells full from empty when the addresses match
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;

    logic fifo_empty;
    logic rd_en;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW])
                     && (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

    // Refill the output stage when it is empty or being drained
    assign rd_en = !fifo_empty && (!tx_payload_tvalid || tx_payload_tready);

    always_ff @(posedge clk) begin
        if (fifo_wr) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= {rx_payload_tuser, rx_payload_tlast, rx_payload_tdata};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (fifo_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_payload_tvalid <= 1'b0;
        end else if (rd_en) begin
            tx_payload_tvalid <= 1'b1;
        end else if (tx_payload_tready) begin
            tx_payload_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            {tx_payload_tuser, tx_payload_tlast, tx_payload_tdata} <= mem[rd_ptr[FIFO_AW-1:0]];
        end
    end

    // Write pointer never laps the read pointer
    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst)
        fifo_wr |-> !fifo_full
    );

endmodule

//--- hw/first_byte_led.sv
/*
 * Latches the first outgoing payload byte of each frame onto the LEDs
 */
`timescale 1ns/1ps

module first_byte_led
    import udp_echo_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // Monitored output stream
    input  logic [DATA_W-1:0] tx_payload_tdata,
    input  logic              tx_payload_tvalid,
    input  logic              tx_payload_tready,
    input  logic              tx_payload_tlast,

    output logic [DATA_W-1:0] led
);

    logic in_frame;
    logic beat_xfer;

    assign beat_xfer = tx_payload_tvalid && tx_payload_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            led      <= '0;
        end else if (beat_xfer) begin
            if (!in_frame) begin
                led <= tx_payload_tdata;
            end
            // A single-beat frame never opens the flag
            in_frame <= !tx_payload_tlast;
        end
    end

endmodule

//--- hw/udp_echo_core.sv
/*
 * UDP echo core top level
 * Echoes datagrams sent to the echo port, drops all others
 */
`timescale 1ns/1ps

module udp_echo_core
    import udp_echo_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // Received UDP header
    input  logic              rx_hdr_valid,
    output logic              rx_hdr_ready,
    input  logic [IP_W-1:0]   rx_ip_source_ip,
    // Local address, supplied again by the downstream stack on reply
    input  logic [IP_W-1:0]   rx_ip_dest_ip,
    input  logic [PORT_W-1:0] rx_source_port,
    input  logic [PORT_W-1:0] rx_dest_port,
    input  logic [LEN_W-1:0]  rx_length,

    // Received UDP payload
    input  logic [DATA_W-1:0] rx_payload_tdata,
    input  logic              rx_payload_tvalid,
    output logic              rx_payload_tready,
    input  logic              rx_payload_tlast,
    input  logic              rx_payload_tuser,

    // Reply UDP header
    output logic              tx_hdr_valid,
    input  logic              tx_hdr_ready,
    output logic [IP_W-1:0]   tx_ip_dest_ip,
    output logic [PORT_W-1:0] tx_source_port,
    output logic [PORT_W-1:0] tx_dest_port,
    output logic [LEN_W-1:0]  tx_length,

    // Reply UDP payload
    output logic [DATA_W-1:0] tx_payload_tdata,
    output logic              tx_payload_tvalid,
    input  logic              tx_payload_tready,
    output logic              tx_payload_tlast,
    output logic              tx_payload_tuser,

    output logic [DATA_W-1:0] led
);

    logic hdr_load;
    logic fifo_wr;
    logic fifo_full;

    udp_echo_ctrl i_udp_echo_ctrl (
        .clk               (clk),
        .rst               (rst),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_dest_port      (rx_dest_port),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tready (rx_payload_tready),
        .tx_hdr_valid      (tx_hdr_valid),
        .hdr_load          (hdr_load),
        .fifo_full         (fifo_full),
        .fifo_wr           (fifo_wr)
    );

    reply_hdr_reg i_reply_hdr_reg (
        .clk             (clk),
        .rst             (rst),
        .hdr_load        (hdr_load),
        .rx_ip_source_ip (rx_ip_source_ip),
        .rx_source_port  (rx_source_port),
        .rx_dest_port    (rx_dest_port),
        .rx_length       (rx_length),
        .tx_hdr_valid    (tx_hdr_valid),
        .tx_hdr_ready    (tx_hdr_ready),
        .tx_ip_dest_ip   (tx_ip_dest_ip),
        .tx_source_port  (tx_source_port),
        .tx_dest_port    (tx_dest_port),
        .tx_length       (tx_length)
    );

    payload_fifo i_payload_fifo (
        .clk               (clk),
        .rst               (rst),
        .fifo_wr           (fifo_wr),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tuser  (rx_payload_tuser),
        .fifo_full         (fifo_full),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tlast  (tx_payload_tlast),
        .tx_payload_tuser  (tx_payload_tuser),
        .tx_payload_tready (tx_payload_tready)
    );

    first_byte_led i_first_byte_led (
        .clk               (clk),
        .rst               (rst),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast),
        .led               (led)
    );

endmodule

//--- dv/udp_echo_tb.sv
/*
 * Testbench for the UDP echo core
 * Random echo and drop datagrams under output back-pressure, checked against a reference model
 */
`timescale 1ns/1ps

module udp_echo_tb
    import udp_echo_pkg::*;
();

    localparam int N_FRAMES       = 40;
    localparam int MAX_LEN        = 40;
    localparam int TIMEOUT_CYCLES = N_FRAMES * MAX_LEN * 20;
    localparam int HDR_W          = IP_W + 2 * PORT_W + LEN_W;

    logic              clk;
    logic              rst;
    logic              rx_hdr_valid;
    logic              rx_hdr_ready;
    logic [IP_W-1:0]   rx_ip_source_ip;
    logic [IP_W-1:0]   rx_ip_dest_ip;
    logic [PORT_W-1:0] rx_source_port;
    logic [PORT_W-1:0] rx_dest_port;
    logic [LEN_W-1:0]  rx_length;
    logic [DATA_W-1:0] rx_payload_tdata;
    logic              rx_payload_tvalid;
    logic              rx_payload_tready;
    logic              rx_payload_tlast;
    logic              rx_payload_tuser;
    logic              tx_hdr_valid;
    logic              tx_hdr_ready;
    logic [IP_W-1:0]   tx_ip_dest_ip;
    logic [PORT_W-1:0] tx_source_port;
    logic [PORT_W-1:0] tx_dest_port;
    logic [LEN_W-1:0]  tx_length;
    logic [DATA_W-1:0] tx_payload_tdata;
    logic              tx_payload_tvalid;
    logic              tx_payload_tready;
    logic              tx_payload_tlast;
    logic              tx_payload_tuser;
    logic [DATA_W-1:0] led;

    integer seed       = 32'h21b;
    integer ready_seed = ~32'h21b;

    // Expected output, filled only by echoed frames
    logic [HDR_W-1:0]  hdr_q[$];
    logic [DATA_W-1:0] data_q[$];
    logic              last_q[$];
    logic              user_q[$];

    udp_echo_core i_udp_echo_core (
        .clk               (clk),
        .rst               (rst),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_ip_source_ip   (rx_ip_source_ip),
        .rx_ip_dest_ip     (rx_ip_dest_ip),
        .rx_source_port    (rx_source_port),
        .rx_dest_port      (rx_dest_port),
        .rx_length         (rx_length),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tready (rx_payload_tready),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tuser  (rx_payload_tuser),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_ip_dest_ip     (tx_ip_dest_ip),
        .tx_source_port    (tx_source_port),
        .tx_dest_port      (tx_dest_port),
        .tx_length         (tx_length),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast),
        .tx_payload_tuser  (tx_payload_tuser),
        .led               (led)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reply goes back to the sender from the port it targeted
    // Packed as {dest_ip, source_port, dest_port, length}
    function automatic logic [HDR_W-1:0] expected_reply(
        input logic [IP_W-1:0]   src_ip,
        input logic [PORT_W-1:0] src_port,
        input logic [PORT_W-1:0] dst_port,
        input logic [LEN_W-1:0]  length
    );
        return {src_ip, dst_port, src_port, length};
    endfunction

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_with_failure($sformatf("Mismatch at %0t ns: %s", $time, msg));
    endtask

    task automatic check_hdr(
        input logic [IP_W-1:0]   got_ip,
        input logic [PORT_W-1:0] got_sport,
        input logic [PORT_W-1:0] got_dport,
        input logic [LEN_W-1:0]  got_len,
        input logic [HDR_W-1:0]  exp
    );
        if ({got_ip, got_sport, got_dport, got_len} !== exp) begin
            report_mismatch($sformatf(
                "header %h %0d %0d %0d, expected %h %0d %0d %0d",
                got_ip, got_sport, got_dport, got_len, exp[HDR_W-1 -: IP_W],
                exp[LEN_W+PORT_W +: PORT_W], exp[LEN_W +: PORT_W], exp[LEN_W-1:0]));
        end
    endtask

    task automatic check_beat(
        input logic [DATA_W-1:0] got_data,
        input logic              got_last,
        input logic              got_user,
        input logic [DATA_W-1:0] exp_data,
        input logic              exp_last,
        input logic              exp_user
    );
        if (got_data !== exp_data || got_last !== exp_last || got_user !== exp_user) begin
            report_mismatch($sformatf("beat data %h last %b user %b, expected %h last %b user %b",
                got_data, got_last, got_user, exp_data, exp_last, exp_user));
        end
    endtask

    task automatic check_led(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("led %h, expected %h", got, exp));
        end
    endtask

    // Called at a falling edge, returns at a falling edge
    // Ready comes from registered state, so it is settled between edges
    task automatic send_header(
        input logic [IP_W-1:0]   sip,
        input logic [IP_W-1:0]   dip,
        input logic [PORT_W-1:0] sport,
        input logic [PORT_W-1:0] dport,
        input logic [LEN_W-1:0]  ulen
    );
        rx_hdr_valid    = 1'b1;
        rx_ip_source_ip = sip;
        rx_ip_dest_ip   = dip;
        rx_source_port  = sport;
        rx_dest_port    = dport;
        rx_length       = ulen;
        while (!rx_hdr_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        // Scramble fields so a late capture shows up
        rx_ip_source_ip = $random(seed);
        rx_dest_port    = ~dport;
    endtask

    task automatic send_beat(input logic [DATA_W-1:0] data, input logic last, input logic user);
        rx_payload_tvalid = 1'b1;
        rx_payload_tdata  = data;
        rx_payload_tlast  = last;
        rx_payload_tuser  = user;
        while (!rx_payload_tready) begin
            @(negedge clk);
        end
        @(negedge clk);
        rx_payload_tvalid = 1'b0;
    endtask

    task automatic send_frame(input logic echo, input int len);
        logic [IP_W-1:0]   sip;
        logic [IP_W-1:0]   dip;
        logic [PORT_W-1:0] sport;
        logic [PORT_W-1:0] dport;
        logic [LEN_W-1:0]  ulen;
        logic [31:0]       r;
        sip   = $random(seed);
        dip   = $random(seed);
        r     = $random(seed);
        sport = r[15:0];
        dport = echo ? ECHO_PORT : r[31:16];
        if (!echo && dport == ECHO_PORT) begin
            dport = dport ^ 16'h1;
        end
        // UDP length counts the 8-byte header
        ulen = LEN_W'(len + 8);
        if (echo) begin
            hdr_q.push_back(expected_reply(sip, sport, dport, ulen));
        end
        send_header(sip, dip, sport, dport, ulen);
        for (int i = 0; i < len; i++) begin
            r = $random(seed);
            if (r[31:30] == 2'b00) begin
                repeat (int'(r[29:28]) + 1) @(negedge clk);
            end
            if (echo) begin
                data_q.push_back(r[7:0]);
                last_q.push_back(i == len - 1);
                user_q.push_back(r[8]);
            end
            send_beat(r[7:0], i == len - 1, r[8]);
        end
    endtask

    initial begin : main
        logic [31:0] r;
        rst               = 1'b1;
        rx_hdr_valid      = 1'b0;
        rx_ip_source_ip   = '0;
        rx_ip_dest_ip     = '0;
        rx_source_port    = '0;
        rx_dest_port      = '0;
        rx_length         = '0;
        rx_payload_tdata  = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
        rx_payload_tuser  = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Idle outputs before any stimulus
        if (tx_hdr_valid !== 1'b0 || tx_payload_tvalid !== 1'b0 || rx_hdr_ready !== 1'b1) begin
            report_mismatch($sformatf("idle tx_hdr_valid %b tx_payload_tvalid %b rx_hdr_ready %b",
                tx_hdr_valid, tx_payload_tvalid, rx_hdr_ready));
        end
        check_led(led, '0);

        // Single byte, FIFO overrun length, then a long drop
        send_frame(1'b1, 1);
        send_frame(1'b1, MAX_LEN);
        send_frame(1'b0, MAX_LEN);
        for (int f = 3; f < N_FRAMES; f++) begin
            r = $random(seed);
            send_frame(r[1:0] != 2'b00, int'(r[15:8]) % MAX_LEN + 1);
        end

        while (hdr_q.size() != 0 || data_q.size() != 0) begin
            @(posedge clk);
        end
        // Room for any stray output to reach the compare process
        repeat (20) @(posedge clk);

        $display("TEST PASS");
        $finish;
    end

    // Random stalls on both reply channels, with long bursts to fill the FIFO
    initial begin : ready_driver
        int unsigned stall;
        logic [31:0] r;
        tx_hdr_ready      = 1'b1;
        tx_payload_tready = 1'b1;
        stall             = 0;
        wait (!rst);
        forever begin
            @(negedge clk);
            r = $random(ready_seed);
            if (stall != 0) begin
                stall--;
                tx_payload_tready = 1'b0;
            end else begin
                if (r[15:11] == 5'd0) begin
                    stall = 20;
                end
                tx_payload_tready = (r[2:0] != 3'd0);
            end
            tx_hdr_ready = (r[5:4] != 2'd0);
        end
    end

    initial begin : compare
        logic              in_frame;
        logic [DATA_W-1:0] led_exp;
        logic [DATA_W-1:0] exp_data;
        logic              exp_last;
        logic              exp_user;
        in_frame = 1'b0;
        led_exp  = '0;
        forever begin
            // Sample mid low phase, where outputs and ready inputs are settled
            @(negedge clk);
            #1;
            if (!rst) begin
                // LED takes a frame's first byte one cycle after it leaves
                check_led(led, led_exp);
                if (tx_hdr_valid && tx_hdr_ready) begin
                    if (hdr_q.size() == 0) begin
                        stop_with_failure("Reply header seen with no echo frame outstanding");
                    end else begin
                        check_hdr(tx_ip_dest_ip, tx_source_port, tx_dest_port, tx_length,
                            hdr_q.pop_front());
                    end
                end
                if (tx_payload_tvalid && tx_payload_tready) begin
                    if (data_q.size() == 0) begin
                        stop_with_failure("Payload beat seen with no echo byte outstanding");
                    end else begin
                        exp_data = data_q.pop_front();
                        exp_last = last_q.pop_front();
                        exp_user = user_q.pop_front();
                        check_beat(tx_payload_tdata, tx_payload_tlast, tx_payload_tuser,
                            exp_data, exp_last, exp_user);
                        if (!in_frame) begin
                            led_exp = exp_data;
                        end
                        in_frame = !exp_last;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        stop_with_failure($sformatf("Timeout: run did not finish within %0d cycles",
            TIMEOUT_CYCLES));
    end

endmodule

//--- project.f
hw/udp_echo_pkg.sv
hw/udp_echo_ctrl.sv
hw/reply_hdr_reg.sv
hw/payload_fifo.sv
hw/first_byte_led.sv
hw/udp_echo_core.sv
dv/udp_echo_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= udp_echo_tb
FILELIST  ?= project.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "No pass message in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
